/* build.f */
verilog/vec_pkg.sv
verilog/vsetvl_decode.sv
verilog/vector_csrs.sv
verilog/vector_lane_alu.sv
verilog/vector_unit_top.sv
tests/vector_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the vector unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/100ps -f build.f \
    --top-module vector_unit_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vvector_unit_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
    exit 1
fi
exit 0

/* tests/vector_cases.txt */
# columns in hex  instr rs1_value rs2_value vs1 vs2 vd_old exp_vtype exp_vl exp_vd kind
# kind 0 is a configuration, 1 a result strobe, 2 an illegal strobe
009170D7 14 0 0 0 0 9 8 0 0
003170D7 64 0 0 0 0 3 40 0 0
012170D7 3 0 0 0 0 12 3 0 0
C486F0D7 63 0 0 0 0 48 4 0 0
C071F0D7 1F 0 0 0 0 7 3 0 0
011070D7 2 0 0 0 0 11 4 0 0
00907057 6 0 0 0 0 9 4 0 0
01807057 6 0 0 0 0 18 1 0 0
803170D7 6 C0 0 0 0 C0 6 0 0
000170D7 6 0 0 0 0 0 6 0 0
02218257 0 0 1010101010208001 0102030405F080FF AAAAAAAAAAAAAAAA 0 6 AAAA131415100000 1
0A218257 0 0 1010101010208001 0102030405F080FF AAAAAAAAAAAAAAAA 0 6 AAAAF3F4F5D000FE 1
048170D7 3 0 0 0 0 48 3 0 0
02218257 0 0 0002000180000F0F 0001FFFF80001234 5555555555555555 48 3 FFFF000000002143 1
010170D7 2 0 0 0 0 10 2 0 0
0A218257 0 0 0000000100000001 1234567800000000 DEADBEEFCAFEF00D 10 2 12345677FFFFFFFF 1
018170D7 5 0 0 0 0 18 1 0 0
02218257 0 0 0000000000000002 FFFFFFFFFFFFFFFF 0 18 1 0000000000000001 1
018170D7 0 0 0 0 0 18 0 0 0
02218257 0 0 1111111111111111 2222222222222222 0123456789ABCDEF 18 0 0123456789ABCDEF 1
00D170D7 4 0 0 0 0 80000000 0 0 0
02218257 0 0 1 2 0 80000000 0 0 2
803170D7 40 A 0 0 0 A 10 0 0
02218257 0 0 0001FFFF00030004 7FFF0001FFFE0003 0 A 10 8000000000010007 1
01E170D7 4 0 0 0 0 80000000 0 0 0
0A218257 0 0 1 2 0 80000000 0 0 2
009170D7 14 0 0 0 0 9 8 0 0
06218257 0 0 1 2 0 9 8 0 2
020170D7 4 0 0 0 0 80000000 0 0 0
011070D7 2 0 0 0 0 11 4 0 0
004170D7 4 0 0 0 0 80000000 0 0 0
00000013 0 0 0 0 0 80000000 0 0 2

/* tests/vector_unit_tb.sv */
module vector_unit_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int VLEN      = 64;
    localparam int MAX_CASES = 64;
    localparam int TIMEOUT   = 20;    // cycles allowed for a strobe

    localparam logic [3:0] KIND_CFG = 4'd0;    // configuration without strobe
    localparam logic [3:0] KIND_RES = 4'd1;    // expects result_valid_o
    localparam logic [3:0] KIND_ILL = 4'd2;    // expects illegal_o

    logic            clk;
    logic            reset_n;
    logic [31:0]     instr_i;
    logic            instr_valid_i;
    logic [31:0]     rs1_value_i;
    logic [31:0]     rs2_value_i;
    logic [VLEN-1:0] vs1_data_i;
    logic [VLEN-1:0] vs2_data_i;
    logic [VLEN-1:0] vd_old_i;
    logic [VLEN-1:0] vd_data_o;
    logic            result_valid_o;
    logic            illegal_o;
    logic [31:0]     vtype_o;
    logic [31:0]     vl_o;

    // one entry per line of the cases file
    logic [31:0]     c_instr  [MAX_CASES];
    logic [31:0]     c_rs1v   [MAX_CASES];
    logic [31:0]     c_rs2v   [MAX_CASES];
    logic [VLEN-1:0] c_vs1    [MAX_CASES];
    logic [VLEN-1:0] c_vs2    [MAX_CASES];
    logic [VLEN-1:0] c_vd_old [MAX_CASES];
    logic [31:0]     c_vtype  [MAX_CASES];
    logic [31:0]     c_vl     [MAX_CASES];
    logic [VLEN-1:0] c_vd     [MAX_CASES];
    logic [3:0]      c_kind   [MAX_CASES];
    int              n_cases;
    int              errors;

    vector_unit_top #(.VLEN(VLEN)) dut0 (
        .clk            (clk),
        .reset_n        (reset_n),
        .instr_i        (instr_i),
        .instr_valid_i  (instr_valid_i),
        .rs1_value_i    (rs1_value_i),
        .rs2_value_i    (rs2_value_i),
        .vs1_data_i     (vs1_data_i),
        .vs2_data_i     (vs2_data_i),
        .vd_old_i       (vd_old_i),
        .vd_data_o      (vd_data_o),
        .result_valid_o (result_valid_o),
        .illegal_o      (illegal_o),
        .vtype_o        (vtype_o),
        .vl_o           (vl_o)
    );

    always #2 clk = ~clk;    // 4 ns period

    task automatic load_cases();
        int              fd;
        int              cnt;
        string           line;
        logic [31:0]     instr, rs1v, rs2v, vtype, vl;
        logic [VLEN-1:0] vs1, vs2, vd_old, vd;
        logic [3:0]      kind;
        fd = $fopen("tests/vector_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open tests/vector_cases.txt");
            errors++;
        end else begin
            while (!$feof(fd) && n_cases < MAX_CASES) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line.getc(0) != "#") begin    // skip blanks and notes
                    cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h",
                                  instr, rs1v, rs2v, vs1, vs2, vd_old, vtype, vl, vd, kind);
                    if (cnt == 10 && kind <= KIND_ILL) begin
                        c_instr[n_cases]  = instr;
                        c_rs1v[n_cases]   = rs1v;
                        c_rs2v[n_cases]   = rs2v;
                        c_vs1[n_cases]    = vs1;
                        c_vs2[n_cases]    = vs2;
                        c_vd_old[n_cases] = vd_old;
                        c_vtype[n_cases]  = vtype;
                        c_vl[n_cases]     = vl;
                        c_vd[n_cases]     = vd;
                        c_kind[n_cases]   = kind;
                        n_cases++;
                    end else begin
                        $display("malformed line in the cases file: %s", line);
                        errors++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // driven with NBAs and sampled by the DUT at the next rising edge
    task automatic issue_case(input int k);
        instr_i       <= c_instr[k];
        instr_valid_i <= 1'b1;
        rs1_value_i   <= c_rs1v[k];
        rs2_value_i   <= c_rs2v[k];
        vs1_data_i    <= c_vs1[k];
        vs2_data_i    <= c_vs2[k];
        vd_old_i      <= c_vd_old[k];
    endtask

    task automatic drive_idle();
        instr_valid_i <= 1'b0;    // operands may stay while nothing is issued
    endtask

    task automatic check_value(input string name, input logic [VLEN-1:0] got,
                               input logic [VLEN-1:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    // samples on falling edges well clear of the DUT's rising edge
    task automatic wait_strobe(input int k, output bit seen);
        int cyc;
        seen = 1'b0;
        for (cyc = 0; cyc < TIMEOUT && !seen; cyc++) begin
            @(negedge clk);
            if (c_kind[k] == KIND_RES) begin
                seen = result_valid_o;
            end else begin
                seen = illegal_o;
            end
        end
    endtask

    initial begin
        bit seen;
        clk           = 1'b0;
        reset_n       = 1'b0;
        instr_i       = '0;
        instr_valid_i = 1'b0;
        rs1_value_i   = '0;
        rs2_value_i   = '0;
        vs1_data_i    = '0;
        vs2_data_i    = '0;
        vd_old_i      = '0;
        errors        = 0;
        n_cases       = 0;
        load_cases();
        if (n_cases == 0) begin
            $display("no cases were read from the cases file");
            errors++;
        end

        repeat (16) @(posedge clk);
        reset_n <= 1'b1;
        @(negedge clk);
        check_value("vtype_o", VLEN'(vtype_o), '0);    // reset state
        check_value("vl_o", VLEN'(vl_o), '0);
        check_value("result_valid_o", VLEN'(result_valid_o), '0);
        check_value("illegal_o", VLEN'(illegal_o), '0);

        @(posedge clk);
        if (n_cases > 0) begin
            issue_case(0);
        end
        for (int k = 0; k < n_cases; k++) begin
            @(posedge clk);    // case k accepted on this edge
            // a configuration is followed straight away by the next case
            if (c_kind[k] == KIND_CFG && k + 1 < n_cases) begin
                issue_case(k + 1);
            end else begin
                drive_idle();
            end
            if (c_kind[k] == KIND_CFG) begin
                @(negedge clk);
                check_value("result_valid_o", VLEN'(result_valid_o), '0);
                check_value("illegal_o", VLEN'(illegal_o), '0);
            end else begin
                wait_strobe(k, seen);
                if (!seen) begin
                    $display("case %0d got no %s strobe within %0d cycles", k,
                             (c_kind[k] == KIND_RES) ? "result" : "illegal", TIMEOUT);
                    errors++;
                end else if (c_kind[k] == KIND_RES) begin
                    check_value("vd_data_o", vd_data_o, c_vd[k]);
                    check_value("illegal_o", VLEN'(illegal_o), '0);
                end else begin
                    check_value("result_valid_o", VLEN'(result_valid_o), '0);
                end
            end
            check_value("vtype_o", VLEN'(vtype_o), VLEN'(c_vtype[k]));
            check_value("vl_o", VLEN'(vl_o), VLEN'(c_vl[k]));
            if (c_kind[k] != KIND_CFG && k + 1 < n_cases) begin
                @(posedge clk);
                issue_case(k + 1);
            end
        end

        @(posedge clk);
        $display("%0d errors over %0d cases", errors, n_cases);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* verilog/vec_pkg.sv */
package vec_pkg;

    // decoded operation, VNONE when nothing is issued
    typedef enum logic [2:0] {
        VNONE    = 3'd0,
        VSETVLI  = 3'd1,
        VSETIVLI = 3'd2,
        VSETVL   = 3'd3,
        VADD     = 3'd4,     // vadd.vv
        VSUB     = 3'd5,     // vsub.vv
        VILLEGAL = 3'd6      // any other encoding
    } vec_op_e;

    // selected element width, codes 4..7 reserved
    typedef enum logic [2:0] {
        EW8  = 3'd0,
        EW16 = 3'd1,
        EW32 = 3'd2,
        EW64 = 3'd3
    } vew_e;

    // register grouping, code 4 reserved
    typedef enum logic [2:0] {
        LMUL_1   = 3'd0,
        LMUL_2   = 3'd1,
        LMUL_4   = 3'd2,
        LMUL_8   = 3'd3,
        LMUL_1_8 = 3'd5,     // fractional, divides the element count
        LMUL_1_4 = 3'd6,
        LMUL_1_2 = 3'd7
    } vlmul_e;

    // major opcode of all vector instructions
    localparam logic [6:0] OPC_OPV = 7'b1010111;

    // funct3 selects the operand category
    localparam logic [2:0] F3_OPCFG = 3'b111;    // vset* family
    localparam logic [2:0] F3_OPIVV = 3'b000;    // vector-vector integer

    // funct6 in bits 31:26
    localparam logic [5:0] F6_VADD = 6'b000000;
    localparam logic [5:0] F6_VSUB = 6'b000010;

endpackage

/* verilog/vector_csrs.sv */
module vector_csrs #(
    parameter int VLEN = 64
) (
    input  logic                         clk,
    input  logic                         reset_n,
    input  vec_pkg::vec_op_e             vec_op_i,
    input  logic [4:0]                   rs1_i,
    input  logic [4:0]                   rd_i,
    input  logic [10:0]                  zimm_i,
    input  logic [31:0]                  rs1_value_i,
    input  logic [31:0]                  rs2_value_i,
    output logic [31:0]                  vtype_o,
    output logic [31:0]                  vl_o,
    output vec_pkg::vew_e                vsew_o,
    output logic [$clog2(VLEN+1)-1:0]    vl_elems_o,
    output logic                         vta_o,
    output logic                         vill_o
);

    localparam int VLENB = VLEN / 8;
    localparam int VLW   = $clog2(VLEN + 1);    // wide enough for vl == VLEN

    logic           is_cfg;
    logic           ma_next, ta_next;
    logic [2:0]     sew_raw, lmul_raw;          // raw fields, may hold reserved codes
    logic           cfg_bad;
    logic [1:0]     frac_shift;
    logic [VLW-1:0] elems_per_reg, vl_max, vl_grant;
    logic [31:0]    avl;                        // requested length
    logic [31:0]    vl_max_w;

    // stored configuration
    logic            vill_q, vma_q, vta_q;
    vec_pkg::vew_e   vsew_q;
    vec_pkg::vlmul_e vlmul_q;
    logic [VLW-1:0]  vl_q;

    assign is_cfg = vec_op_i inside {vec_pkg::VSETVLI, vec_pkg::VSETIVLI, vec_pkg::VSETVL};

    // vsetvl reads vtype from the scalar, the immediate forms from zimm
    always_comb begin
        if (vec_op_i == vec_pkg::VSETVL) begin
            ma_next  = rs2_value_i[7];
            ta_next  = rs2_value_i[6];
            sew_raw  = rs2_value_i[5:3];
            lmul_raw = rs2_value_i[2:0];
        end else begin
            ma_next  = zimm_i[7];
            ta_next  = zimm_i[6];
            sew_raw  = zimm_i[5:3];
            lmul_raw = zimm_i[2:0];
        end
    end

    // reserved codes, or a fraction too small for the element width
    always_comb begin
        cfg_bad = sew_raw[2] | (lmul_raw == 3'd4);
        case (lmul_raw)
            3'd5:    cfg_bad = cfg_bad | (sew_raw != 3'd0);     // 1/8 only with EW8
            3'd6:    cfg_bad = cfg_bad | (sew_raw[1:0] >= 2'd2); // 1/4 up to EW16
            3'd7:    cfg_bad = cfg_bad | (sew_raw[1:0] == 2'd3); // 1/2 up to EW32
            default: ;
        endcase
    end

    // vlmax = (VLENB >> sew) scaled by lmul
    assign elems_per_reg = VLW'(VLENB) >> sew_raw[1:0];
    assign frac_shift    = 2'd0 - lmul_raw[1:0];    // 5->3, 6->2, 7->1
    assign vl_max        = lmul_raw[2] ? (elems_per_reg >> frac_shift)
                                       : (elems_per_reg << lmul_raw[1:0]);
    assign vl_max_w      = 32'(vl_max);

    always_comb begin
        if (vec_op_i == vec_pkg::VSETIVLI) begin
            avl = {27'b0, rs1_i};               // uimm in the rs1 slot
        end else if (rd_i != 5'd0 && rs1_i == 5'd0) begin
            avl = vl_max_w;                     // ask for everything
        end else if (rd_i == 5'd0 && rs1_i == 5'd0) begin
            avl = 32'(vl_q);                    // keep current vl
        end else begin
            avl = rs1_value_i;
        end
    end

    assign vl_grant = (avl > vl_max_w) ? vl_max : VLW'(avl);    // cap at vlmax

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            vill_q  <= 1'b0;
            vma_q   <= 1'b0;
            vta_q   <= 1'b0;
            vsew_q  <= vec_pkg::EW8;
            vlmul_q <= vec_pkg::LMUL_1;
            vl_q    <= '0;
        end else if (is_cfg) begin    // only vset* touches the state
            vill_q  <= cfg_bad;
            vma_q   <= ma_next;
            vta_q   <= ta_next;
            vsew_q  <= vec_pkg::vew_e'(sew_raw);
            vlmul_q <= vec_pkg::vlmul_e'(lmul_raw);
            vl_q    <= cfg_bad ? '0 : vl_grant;
        end
    end

    // an illegal setting shows only the vill bit
    assign vtype_o    = vill_q ? 32'h8000_0000
                               : {24'b0, vma_q, vta_q, vsew_q, vlmul_q};
    assign vl_o       = 32'(vl_q);
    assign vsew_o     = vsew_q;
    assign vl_elems_o = vl_q;
    assign vta_o      = vta_q;
    assign vill_o     = vill_q;

endmodule

/* verilog/vector_lane_alu.sv */
module vector_lane_alu #(
    parameter int VLEN = 64
) (
    input  logic                         clk,
    input  logic                         reset_n,
    input  vec_pkg::vec_op_e             vec_op_i,
    input  vec_pkg::vew_e                vsew_i,
    input  logic [$clog2(VLEN+1)-1:0]    vl_i,
    input  logic                         vta_i,
    input  logic                         vill_i,
    input  logic [VLEN-1:0]              vs1_data_i,
    input  logic [VLEN-1:0]              vs2_data_i,
    input  logic [VLEN-1:0]              vd_old_i,
    output logic [VLEN-1:0]              vd_data_o,
    output logic                         result_valid_o,
    output logic                         illegal_o
);

    localparam int VLENB = VLEN / 8;
    localparam int VLW   = $clog2(VLEN + 1);

    logic            is_arith, is_sub;
    logic            do_exec, do_trap;
    logic [1:0]      sew_sh;                 // log2 of element bytes
    logic [VLEN-1:0] res_ew [4];             // one result per element width
    logic [VLEN-1:0] lane_res;
    logic [VLEN-1:0] merged;

    assign is_arith = vec_op_i inside {vec_pkg::VADD, vec_pkg::VSUB};
    assign is_sub   = (vec_op_i == vec_pkg::VSUB);
    assign do_exec  = is_arith & ~vill_i;
    assign do_trap  = (vec_op_i == vec_pkg::VILLEGAL) | (is_arith & vill_i);
    assign sew_sh   = vsew_i[1:0];    // reserved codes only occur with vill set

    // vs2 op vs1 per element, carries stop at the element boundary
    for (genvar w = 0; w < 4; w++) begin : g_width
        localparam int EW = 8 << w;
        for (genvar e = 0; e < VLEN / EW; e++) begin : g_elem
            assign res_ew[w][e*EW +: EW] = is_sub
                ? vs2_data_i[e*EW +: EW] - vs1_data_i[e*EW +: EW]
                : vs2_data_i[e*EW +: EW] + vs1_data_i[e*EW +: EW];
        end
    end

    assign lane_res = res_ew[sew_sh];

    // body/tail decided per byte, element index = byte index >> sew
    always_comb begin
        merged = vd_old_i;
        for (int b = 0; b < VLENB; b++) begin
            if (VLW'(b >> sew_sh) < vl_i) begin
                merged[b*8 +: 8] = lane_res[b*8 +: 8];    // body
            end else if (vta_i) begin
                merged[b*8 +: 8] = 8'hff;                 // tail agnostic
            end else begin
                merged[b*8 +: 8] = vd_old_i[b*8 +: 8];    // tail undisturbed
            end
        end
    end

    // strobes are one cycle wide, one item per cycle
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            result_valid_o <= 1'b0;
            illegal_o      <= 1'b0;
        end else begin
            result_valid_o <= do_exec;
            illegal_o      <= do_trap;
        end
    end

    // data register, loaded only on an executed op
    always_ff @(posedge clk) begin
        if (do_exec) begin
            vd_data_o <= merged;
        end
    end

endmodule

/* verilog/vector_unit_top.sv */
module vector_unit_top #(
    parameter int VLEN = 64
) (
    input  logic            clk,
    input  logic            reset_n,
    input  logic [31:0]     instr_i,
    input  logic            instr_valid_i,
    input  logic [31:0]     rs1_value_i,
    input  logic [31:0]     rs2_value_i,
    input  logic [VLEN-1:0] vs1_data_i,
    input  logic [VLEN-1:0] vs2_data_i,
    input  logic [VLEN-1:0] vd_old_i,
    output logic [VLEN-1:0] vd_data_o,
    output logic            result_valid_o,
    output logic            illegal_o,
    output logic [31:0]     vtype_o,
    output logic [31:0]     vl_o
);

    localparam int VLW = $clog2(VLEN + 1);

    vec_pkg::vec_op_e dec_op;       // raw decode
    vec_pkg::vec_op_e vec_op;       // qualified by instr_valid_i
    logic [4:0]       rs1_addr, rd_addr;
    logic [10:0]      zimm;
    vec_pkg::vew_e    vsew;
    logic [VLW-1:0]   vl_elems;
    logic             vta, vill;

    vsetvl_decode u_decode (
        .instr_i  (instr_i),
        .vec_op_o (dec_op),
        .rs1_o    (rs1_addr),
        .rd_o     (rd_addr),
        .zimm_o   (zimm)
    );

    // no strobe, no operation
    assign vec_op = instr_valid_i ? dec_op : vec_pkg::VNONE;

    vector_csrs #(.VLEN(VLEN)) u_csrs (
        .clk         (clk),
        .reset_n     (reset_n),
        .vec_op_i    (vec_op),
        .rs1_i       (rs1_addr),
        .rd_i        (rd_addr),
        .zimm_i      (zimm),
        .rs1_value_i (rs1_value_i),
        .rs2_value_i (rs2_value_i),
        .vtype_o     (vtype_o),
        .vl_o        (vl_o),
        .vsew_o      (vsew),
        .vl_elems_o  (vl_elems),
        .vta_o       (vta),
        .vill_o      (vill)
    );

    vector_lane_alu #(.VLEN(VLEN)) u_alu (
        .clk            (clk),
        .reset_n        (reset_n),
        .vec_op_i       (vec_op),
        .vsew_i         (vsew),
        .vl_i           (vl_elems),
        .vta_i          (vta),
        .vill_i         (vill),
        .vs1_data_i     (vs1_data_i),
        .vs2_data_i     (vs2_data_i),
        .vd_old_i       (vd_old_i),
        .vd_data_o      (vd_data_o),
        .result_valid_o (result_valid_o),
        .illegal_o      (illegal_o)
    );

endmodule

/* verilog/vsetvl_decode.sv */
module vsetvl_decode (
    input  logic [31:0]      instr_i,
    output vec_pkg::vec_op_e vec_op_o,
    output logic [4:0]       rs1_o,
    output logic [4:0]       rd_o,
    output logic [10:0]      zimm_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [5:0] funct6;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct6 = instr_i[31:26];

    // register fields sit at the same place in every form
    assign rs1_o = instr_i[19:15];    // also uimm of vsetivli
    assign rd_o  = instr_i[11:7];

    always_comb begin
        vec_op_o = vec_pkg::VILLEGAL;     // default, anything not matched below
        zimm_o   = instr_i[30:20];        // vsetvli layout, 11 bits

        if (opcode == vec_pkg::OPC_OPV) begin
            if (funct3 == vec_pkg::F3_OPCFG) begin
                // bits 31:30 pick the configuration form
                if (!instr_i[31]) begin
                    vec_op_o = vec_pkg::VSETVLI;
                end else if (instr_i[30]) begin
                    vec_op_o = vec_pkg::VSETIVLI;
                    zimm_o   = {1'b0, instr_i[29:20]};    // only 10 bits encoded
                end else if (instr_i[29:25] == 5'b0) begin
                    vec_op_o = vec_pkg::VSETVL;           // vtype comes from rs2
                end
            end else if (funct3 == vec_pkg::F3_OPIVV) begin
                // vm bit is ignored, masking is not supported
                if (funct6 == vec_pkg::F6_VADD) begin
                    vec_op_o = vec_pkg::VADD;
                end else if (funct6 == vec_pkg::F6_VSUB) begin
                    vec_op_o = vec_pkg::VSUB;
                end
            end
        end
    end

endmodule
